// File: source/synapse_pkg.sv
package synapse_pkg;

    // register file
    localparam int top_reg = 7;
    localparam int debug_peek_reg = top_reg;
    localparam int word_w = 16;

    // program memory
    localparam int prog_depth = 64;
    localparam int prog_aw = $clog2(prog_depth);

    // serial bit period in sysclk cycles
    localparam int baud_div = 8;
    localparam int baud_cnt_w = $clog2(baud_div);
    localparam logic [baud_cnt_w-1:0] baud_last = baud_cnt_w'(baud_div - 1);
    // mid-bit point of the start bit
    localparam logic [baud_cnt_w-1:0] baud_half = baud_cnt_w'(baud_div / 2 - 1);

    // top nibble of an instruction word
    typedef enum logic [3:0] {
        op_nop = 4'h0,
        op_ldi = 4'h1,
        op_rd  = 4'h2,
        op_wr  = 4'h3,
        op_add = 4'h4,
        op_jmp = 4'h5,
        op_hlt = 4'hf
    } opcode_t;

    // host command bytes, printable for terminal use
    typedef enum logic [7:0] {
        cmd_halt = 8'h48,
        cmd_run  = 8'h52,
        cmd_load = 8'h4c,
        cmd_peek = 8'h50,
        cmd_avwr = 8'h57
    } visor_cmd_t;

endpackage

// File: source/synapse316.sv
`timescale 1ns/10ps

module synapse316 (
    input  logic                            sysclk,
    input  logic                            arst_n,
    input  logic                            tg_reset,
    input  logic [synapse_pkg::word_w-1:0]  code_in,
    input  logic                            code_ready,
    input  logic [synapse_pkg::word_w-1:0]  r [0:synapse_pkg::top_reg],
    output logic [synapse_pkg::prog_aw-1:0] code_addr,
    output logic [synapse_pkg::top_reg:0]   r_read,
    output logic [synapse_pkg::top_reg:0]   r_load,
    output logic [synapse_pkg::word_w-1:0]  r_load_data
);

    import synapse_pkg::*;

    logic [prog_aw-1:0] pc;
    logic [word_w-1:0]  acc;
    logic               halted;
    logic               exec;
    opcode_t            op;
    logic [7:0]         imm;
    logic [2:0]         idx;
    logic [top_reg:0]   idx_onehot;

    // instruction fields
    assign op  = opcode_t'(code_in[word_w-1 -: 4]);
    assign imm = code_in[7:0];
    assign idx = code_in[2:0];

    // one instruction per cycle with a valid code word
    assign exec = code_ready && !tg_reset && !halted;

    assign code_addr   = pc;
    assign r_load_data = acc;

    always_comb begin
        idx_onehot = '0;
        idx_onehot[idx] = 1'b1;
    end

    // register strobes live only in the execute cycle
    always_comb begin
        r_read = '0;
        r_load = '0;
        if (exec) begin
            case (op)
                op_rd, op_add: begin
                    r_read = idx_onehot;
                end
                op_wr: begin
                    r_load = idx_onehot;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            pc     <= '0;
            acc    <= '0;
            halted <= 1'b0;
        end else if (tg_reset) begin
            // held by the supervisor
            pc     <= '0;
            acc    <= '0;
            halted <= 1'b0;
        end else if (exec) begin
            // pc wraps at prog_depth by its width
            pc <= pc + 1'b1;
            case (op)
                op_ldi: begin
                    acc <= word_w'(imm);
                end
                op_rd: begin
                    acc <= r[idx];
                end
                op_add: begin
                    acc <= acc + r[idx];
                end
                op_jmp: begin
                    pc <= imm[prog_aw-1:0];
                end
                op_hlt: begin
                    // park on the halt until the next target reset
                    pc     <= pc;
                    halted <= 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: source/async_serial.sv
`timescale 1ns/10ps

module async_serial (
    input  logic       sysclk,
    input  logic       arst_n,
    input  logic       rx_line,
    input  logic       tx_valid,
    input  logic [7:0] tx_byte,
    output logic       rx_valid,
    output logic [7:0] rx_byte,
    output logic       tx_line,
    output logic       tx_ready
);

    import synapse_pkg::*;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    typedef enum logic {
        tx_idle,
        tx_send
    } tx_state_t;

    rx_state_t             rx_state;
    logic                  rx_meta;
    logic                  rx_sync;
    logic [baud_cnt_w-1:0] rx_cnt;
    logic [2:0]            rx_bit;
    logic                  rx_sample;

    tx_state_t             tx_state;
    logic [9:0]            tx_sh;
    logic [baud_cnt_w-1:0] tx_cnt;
    logic [3:0]            tx_bit;
    logic                  tx_shift;

    // line is asynchronous to sysclk
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_line;
            rx_sync <= rx_meta;
        end
    end

    assign rx_sample = (rx_state == rx_data) && (rx_cnt == baud_last);

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            rx_state <= rx_idle;
            rx_cnt   <= '0;
            rx_bit   <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (rx_state)
                rx_idle: begin
                    rx_cnt <= '0;
                    if (!rx_sync) begin
                        rx_state <= rx_start;
                    end
                end
                rx_start: begin
                    if (rx_cnt == baud_half) begin
                        rx_cnt <= '0;
                        rx_bit <= '0;
                        // a short glitch is not a start bit
                        rx_state <= rx_sync ? rx_idle : rx_data;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (rx_cnt == baud_last) begin
                        rx_cnt <= '0;
                        rx_bit <= rx_bit + 1'b1;
                        if (rx_bit == 3'd7) begin
                            rx_state <= rx_stop;
                        end
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                default: begin
                    if (rx_cnt == baud_last) begin
                        // framing error drops the byte
                        rx_valid <= rx_sync;
                        rx_state <= rx_idle;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb first
    always_ff @(posedge sysclk) begin
        if (rx_sample) begin
            rx_byte <= {rx_sync, rx_byte[7:1]};
        end
    end

    assign tx_ready = (tx_state == tx_idle);
    assign tx_line  = (tx_state == tx_send) ? tx_sh[0] : 1'b1;
    assign tx_shift = (tx_state == tx_send) && (tx_cnt == baud_last);

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            tx_state <= tx_idle;
            tx_cnt   <= '0;
            tx_bit   <= '0;
        end else if (tx_state == tx_idle) begin
            tx_cnt <= '0;
            tx_bit <= '0;
            if (tx_valid) begin
                tx_state <= tx_send;
            end
        end else if (tx_shift) begin
            tx_cnt <= '0;
            tx_bit <= tx_bit + 1'b1;
            // start, eight data bits, stop
            if (tx_bit == 4'd9) begin
                tx_state <= tx_idle;
            end
        end else begin
            tx_cnt <= tx_cnt + 1'b1;
        end
    end

    always_ff @(posedge sysclk) begin
        if (tx_valid && tx_ready) begin
            tx_sh <= {1'b1, tx_byte, 1'b0};
        end else if (tx_shift) begin
            tx_sh <= {1'b1, tx_sh[9:1]};
        end
    end

endmodule

// File: source/visor.sv
`timescale 1ns/10ps

module visor (
    input  logic                            sysclk,
    input  logic                            arst_n,
    input  logic                            mcu_wait,
    input  logic [synapse_pkg::prog_aw-1:0] tg_code_addr,
    input  logic                            peek_load,
    input  logic [synapse_pkg::word_w-1:0]  peek_wdata,
    input  logic                            async_rx_line,
    input  logic                            av_waitrequest,
    output logic [synapse_pkg::word_w-1:0]  tg_code_in,
    output logic                            tg_code_ready,
    output logic                            tg_reset,
    output logic [synapse_pkg::word_w-1:0]  peek_data,
    output logic                            async_tx_line,
    output logic [synapse_pkg::word_w-1:0]  av_address,
    output logic [synapse_pkg::word_w-1:0]  av_writedata,
    output logic                            av_write
);

    import synapse_pkg::*;

    typedef enum logic {
        ps_cmd,
        ps_arg
    } parse_state_t;

    typedef enum logic [1:0] {
        pk_idle,
        pk_hi,
        pk_lo
    } peek_state_t;

    logic              rx_valid;
    logic [7:0]        rx_byte;
    logic              tx_valid;
    logic [7:0]        tx_byte;
    logic              tx_ready;
    visor_cmd_t        rx_cmd;
    parse_state_t      pstate;
    visor_cmd_t        cur_cmd;
    logic [1:0]        arg_cnt;
    logic [23:0]       args;
    logic              cmd_byte;
    logic              last_arg;
    logic              peek_start;
    peek_state_t       pk_state;
    logic [word_w-1:0] reply_word;
    logic [word_w-1:0] prog_mem [0:prog_depth-1];

    async_serial serial (
        .sysclk   (sysclk),
        .arst_n   (arst_n),
        .rx_line  (async_rx_line),
        .tx_valid (tx_valid),
        .tx_byte  (tx_byte),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte),
        .tx_line  (async_tx_line),
        .tx_ready (tx_ready)
    );

    // code bus, combinational read
    assign tg_code_in    = prog_mem[tg_code_addr];
    assign tg_code_ready = !tg_reset && !mcu_wait;

    // parser takes every byte, a serial byte cannot wait
    assign rx_cmd     = visor_cmd_t'(rx_byte);
    assign cmd_byte   = rx_valid && (pstate == ps_cmd);
    assign last_arg   = rx_valid && (pstate == ps_arg) && (arg_cnt == 2'd0);
    assign peek_start = cmd_byte && (rx_cmd == cmd_peek) && (pk_state == pk_idle);

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            pstate   <= ps_cmd;
            cur_cmd  <= cmd_halt;
            arg_cnt  <= '0;
            tg_reset <= 1'b1;
        end else if (cmd_byte) begin
            case (rx_cmd)
                cmd_halt: begin
                    tg_reset <= 1'b1;
                end
                cmd_run: begin
                    tg_reset <= 1'b0;
                end
                cmd_load: begin
                    pstate  <= ps_arg;
                    cur_cmd <= cmd_load;
                    arg_cnt <= 2'd2;
                end
                cmd_avwr: begin
                    // one bus write in flight at a time
                    if (!av_write) begin
                        pstate  <= ps_arg;
                        cur_cmd <= cmd_avwr;
                        arg_cnt <= 2'd3;
                    end
                end
                default: begin
                end
            endcase
        end else if (rx_valid && (pstate == ps_arg)) begin
            arg_cnt <= arg_cnt - 1'b1;
            if (arg_cnt == 2'd0) begin
                pstate <= ps_cmd;
            end
        end
    end

    // last three bytes seen, the newest one comes straight from rx_byte
    always_ff @(posedge sysclk) begin
        if (rx_valid) begin
            args <= {args[15:0], rx_byte};
        end
    end

    // load: address, data high, data low
    always_ff @(posedge sysclk) begin
        if (last_arg && (cur_cmd == cmd_load)) begin
            prog_mem[args[8 +: prog_aw]] <= {args[7:0], rx_byte};
        end
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            av_write <= 1'b0;
        end else if (last_arg && (cur_cmd == cmd_avwr)) begin
            av_write <= 1'b1;
        end else if (av_write && !av_waitrequest) begin
            av_write <= 1'b0;
        end
    end

    always_ff @(posedge sysclk) begin
        if (last_arg && (cur_cmd == cmd_avwr)) begin
            av_address   <= args[23:8];
            av_writedata <= {args[7:0], rx_byte};
        end
    end

    // peek register, written by the target as r7
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            peek_data <= '0;
        end else if (peek_load) begin
            peek_data <= peek_wdata;
        end
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            pk_state <= pk_idle;
        end else begin
            case (pk_state)
                pk_idle: begin
                    if (peek_start) begin
                        pk_state <= pk_hi;
                    end
                end
                pk_hi: begin
                    if (tx_ready) begin
                        pk_state <= pk_lo;
                    end
                end
                pk_lo: begin
                    // waits out the high byte frame
                    if (tx_ready) begin
                        pk_state <= pk_idle;
                    end
                end
                default: begin
                    pk_state <= pk_idle;
                end
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if (peek_start) begin
            reply_word <= peek_data;
        end
    end

    assign tx_valid = (pk_state != pk_idle);
    assign tx_byte  = (pk_state == pk_hi) ? reply_word[15:8] : reply_word[7:0];

endmodule

// File: source/supervised_synapse316.sv
`timescale 1ns/10ps

module supervised_synapse316 (
    input  logic                           sysclk,
    input  logic                           arst_n,
    input  logic                           mcu_wait,
    input  logic [synapse_pkg::word_w-1:0] r [0:synapse_pkg::top_reg],
    output logic [synapse_pkg::top_reg:0]  r_read,
    output logic [synapse_pkg::top_reg:0]  r_load,
    output logic [synapse_pkg::word_w-1:0] r_load_data,
    input  logic                           dbg_async_rx_line,
    output logic                           dbg_async_tx_line,
    output logic [synapse_pkg::word_w-1:0] dbg_av_address,
    input  logic                           dbg_av_waitrequest,
    output logic [synapse_pkg::word_w-1:0] dbg_av_writedata,
    output logic                           dbg_av_write
);

    import synapse_pkg::*;

    logic [prog_aw-1:0] tg_code_addr;
    logic [word_w-1:0]  tg_code_in;
    logic               tg_code_ready;
    logic               tg_reset;
    wire  [word_w-1:0]  tg_r [0:top_reg];
    logic [top_reg:0]   tg_r_read;
    logic [top_reg:0]   tg_r_load;
    logic [word_w-1:0]  peek_data;

    synapse316 target (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .tg_reset    (tg_reset),
        .code_in     (tg_code_in),
        .code_ready  (tg_code_ready),
        .r           (tg_r),
        .code_addr   (tg_code_addr),
        .r_read      (tg_r_read),
        .r_load      (tg_r_load),
        .r_load_data (r_load_data)
    );

    // top register of the file is the visor's peek register
    assign tg_r[debug_peek_reg] = peek_data;
    for (genvar i = 0; i < debug_peek_reg; i++) begin : g_ext_reg
        assign tg_r[i] = r[i];
    end

    // peek accesses never reach the outside strobes
    assign r_read = {1'b0, tg_r_read[debug_peek_reg-1:0]};
    assign r_load = {1'b0, tg_r_load[debug_peek_reg-1:0]};

    visor visr (
        .sysclk         (sysclk),
        .arst_n         (arst_n),
        .mcu_wait       (mcu_wait),
        .tg_code_addr   (tg_code_addr),
        .peek_load      (tg_r_load[debug_peek_reg]),
        .peek_wdata     (r_load_data),
        .async_rx_line  (dbg_async_rx_line),
        .av_waitrequest (dbg_av_waitrequest),
        .tg_code_in     (tg_code_in),
        .tg_code_ready  (tg_code_ready),
        .tg_reset       (tg_reset),
        .peek_data      (peek_data),
        .async_tx_line  (dbg_async_tx_line),
        .av_address     (dbg_av_address),
        .av_writedata   (dbg_av_writedata),
        .av_write       (dbg_av_write)
    );

endmodule

// File: verification/synapse_checker.sv
`timescale 1ns/10ps

module synapse_checker (
    input logic                           sysclk,
    input logic                           arst_n,
    input logic                           mcu_wait,
    input logic [synapse_pkg::top_reg:0]  r_read,
    input logic [synapse_pkg::top_reg:0]  r_load,
    input logic [synapse_pkg::word_w-1:0] r_load_data,
    input logic                           tx_line,
    input logic [synapse_pkg::word_w-1:0] av_address,
    input logic [synapse_pkg::word_w-1:0] av_writedata,
    input logic                           av_write,
    input logic                           av_waitrequest
);

    import synapse_pkg::*;

    // program image and register values at cmd_run, filled by the testbench
    logic [word_w-1:0] prog [0:prog_depth-1];
    logic [word_w-1:0] start_regs [0:top_reg-1];
    logic [word_w-1:0] model_r7 = '0;
    int                mismatches = 0;
    int                failures = 0;
    int                replies = 0;
    int                av_done = 0;

    logic [2:0]        exp_load_idx [$];
    logic [word_w-1:0] exp_load_data [$];
    logic [2:0]        exp_read_idx [$];
    logic [word_w-1:0] exp_av_addr [$];
    logic [word_w-1:0] exp_av_data [$];

    task automatic note_failure(input string what);
        $display("Error: %s", what);
        failures++;
    endtask

    function automatic int pending();
        return exp_load_idx.size() + exp_read_idx.size();
    endfunction

    function automatic int total_errors();
        return mismatches + failures;
    endfunction

    task automatic expect_av(input logic [word_w-1:0] addr, input logic [word_w-1:0] data);
        exp_av_addr.push_back(addr);
        exp_av_data.push_back(data);
    endtask

    task automatic report();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    endtask

    // instruction-set model, runs from address 0 until op_hlt
    task automatic predict();
        logic [word_w-1:0]  regs [0:top_reg];
        logic [word_w-1:0]  acc;
        logic [word_w-1:0]  w;
        logic [prog_aw-1:0] pc;
        logic [2:0]         i;
        logic               running;
        int                 steps;
        for (int k = 0; k < top_reg; k++) begin
            regs[k] = start_regs[k];
        end
        regs[top_reg] = model_r7;
        acc = '0;
        pc = '0;
        running = 1'b1;
        steps = 0;
        while (running && steps < 4 * prog_depth) begin
            w = prog[pc];
            i = w[2:0];
            pc = pc + 1'b1;
            case (opcode_t'(w[15:12]))
                op_ldi: begin
                    acc = {8'h00, w[7:0]};
                end
                op_rd, op_add: begin
                    if (w[15:12] == op_rd) begin
                        acc = regs[i];
                    end else begin
                        acc = acc + regs[i];
                    end
                    if (int'(i) != debug_peek_reg) begin
                        exp_read_idx.push_back(i);
                    end
                end
                op_wr: begin
                    regs[i] = acc;
                    if (int'(i) != debug_peek_reg) begin
                        exp_load_idx.push_back(i);
                        exp_load_data.push_back(acc);
                    end
                end
                op_jmp: begin
                    pc = w[prog_aw-1:0];
                end
                op_hlt: begin
                    running = 1'b0;
                end
                default: begin
                end
            endcase
            steps++;
        end
        model_r7 = regs[top_reg];
    endtask

    function automatic logic [2:0] strobe_index(input logic [top_reg:0] s);
        logic [2:0] idx;
        idx = '0;
        for (int n = 0; n <= top_reg; n++) begin
            if (s[n]) begin
                idx = 3'(n);
            end
        end
        return idx;
    endfunction

    always @(posedge sysclk) begin
        if (arst_n) begin
            if (r_load[debug_peek_reg] || r_read[debug_peek_reg]) begin
                note_failure("peek register strobe reached the outside ports");
            end
            if (mcu_wait && (r_load != '0 || r_read != '0)) begin
                note_failure("register strobe while mcu_wait was high");
            end
            if (r_load != '0) begin
                if ($countones(r_load) != 1) begin
                    note_failure("r_load is not one-hot");
                end else if (exp_load_idx.size() == 0) begin
                    note_failure("register load that the model does not predict");
                end else begin
                    if (strobe_index(r_load) != exp_load_idx[0]) begin
                        $display("Mismatch r_load: got %h expected %h",
                                 strobe_index(r_load), exp_load_idx[0]);
                        mismatches++;
                    end
                    if (r_load_data != exp_load_data[0]) begin
                        $display("Mismatch r_load_data: got %h expected %h",
                                 r_load_data, exp_load_data[0]);
                        mismatches++;
                    end
                    void'(exp_load_idx.pop_front());
                    void'(exp_load_data.pop_front());
                end
            end
            if (r_read != '0) begin
                if ($countones(r_read) != 1) begin
                    note_failure("r_read is not one-hot");
                end else if (exp_read_idx.size() == 0) begin
                    note_failure("register read that the model does not predict");
                end else begin
                    if (strobe_index(r_read) != exp_read_idx[0]) begin
                        $display("Mismatch r_read: got %h expected %h",
                                 strobe_index(r_read), exp_read_idx[0]);
                        mismatches++;
                    end
                    void'(exp_read_idx.pop_front());
                end
            end
            // completed Avalon write
            if (av_write && !av_waitrequest) begin
                if (exp_av_addr.size() == 0) begin
                    note_failure("Avalon write that no command asked for");
                end else begin
                    if (av_address != exp_av_addr[0]) begin
                        $display("Mismatch av_address: got %h expected %h",
                                 av_address, exp_av_addr[0]);
                        mismatches++;
                    end
                    if (av_writedata != exp_av_data[0]) begin
                        $display("Mismatch av_writedata: got %h expected %h",
                                 av_writedata, exp_av_data[0]);
                        mismatches++;
                    end
                    void'(exp_av_addr.pop_front());
                    void'(exp_av_data.pop_front());
                end
                av_done++;
            end
        end
    end

    // serial receiver for the peek reply, high byte first
    initial begin : tx_monitor
        logic [7:0] b;
        logic [7:0] hi;
        logic       have_hi;
        b = '0;
        hi = '0;
        have_hi = 1'b0;
        forever begin
            @(posedge sysclk);
            if (arst_n && !tx_line) begin
                repeat (baud_div / 2) @(posedge sysclk);
                for (int n = 0; n < 8; n++) begin
                    repeat (baud_div) @(posedge sysclk);
                    b[n] = tx_line;
                end
                repeat (baud_div) @(posedge sysclk);
                if (!tx_line) begin
                    note_failure("peek reply frame has no stop bit");
                end
                if (have_hi) begin
                    if ({hi, b} != model_r7) begin
                        $display("Mismatch peek_reply: got %h expected %h", {hi, b}, model_r7);
                        mismatches++;
                    end
                    replies++;
                    have_hi = 1'b0;
                end else begin
                    hi = b;
                    have_hi = 1'b1;
                end
            end
        end
    end

endmodule

// File: verification/tb_supervised_synapse316.sv
`timescale 1ns/10ps

module tb_supervised_synapse316;

    import synapse_pkg::*;

    localparam int prog_len = 24;
    // frame plus one idle bit between bytes
    localparam int frame_cycles = 11 * baud_div;
    localparam int n_frames = prog_len * 4 + 4 + 1 + 3 * 5;
    localparam int run_limit = 16 * prog_len;
    localparam int total_cycles = n_frames * frame_cycles + 2 * run_limit + 600;
    localparam longint watchdog_ns = longint'(total_cycles) * 20 * 3;

    logic              sysclk = 1'b0;
    logic              arst_n;
    logic              mcu_wait;
    logic              rx_line;
    logic              av_waitrequest = 1'b1;
    logic [word_w-1:0] r [0:top_reg] = '{default: '0};
    logic [top_reg:0]  r_read;
    logic [top_reg:0]  r_load;
    logic [word_w-1:0] r_load_data;
    logic              tx_line;
    logic [word_w-1:0] av_address;
    logic [word_w-1:0] av_writedata;
    logic              av_write;
    logic [word_w-1:0] prog_words [0:prog_len-1];

    always #10 sysclk = ~sysclk;

    supervised_synapse316 supervised_synapse316_i (
        .sysclk             (sysclk),
        .arst_n             (arst_n),
        .mcu_wait           (mcu_wait),
        .r                  (r),
        .r_read             (r_read),
        .r_load             (r_load),
        .r_load_data        (r_load_data),
        .dbg_async_rx_line  (rx_line),
        .dbg_async_tx_line  (tx_line),
        .dbg_av_address     (av_address),
        .dbg_av_waitrequest (av_waitrequest),
        .dbg_av_writedata   (av_writedata),
        .dbg_av_write       (av_write)
    );

    synapse_checker chk (
        .sysclk         (sysclk),
        .arst_n         (arst_n),
        .mcu_wait       (mcu_wait),
        .r_read         (r_read),
        .r_load         (r_load),
        .r_load_data    (r_load_data),
        .tx_line        (tx_line),
        .av_address     (av_address),
        .av_writedata   (av_writedata),
        .av_write       (av_write),
        .av_waitrequest (av_waitrequest)
    );

    // external register file r0..r6 and Avalon slave
    always @(posedge sysclk) begin
        for (int i = 0; i < top_reg; i++) begin
            if (!arst_n) begin
                r[i] <= 16'($urandom);
            end else if (r_load[i]) begin
                r[i] <= r_load_data;
            end
        end
        av_waitrequest <= ($urandom_range(3, 0) != 0);
    end

    // 8N1 frame sent lsb first with one idle bit after it
    task automatic send_byte(input logic [7:0] b);
        logic [10:0] frame;
        frame = {2'b11, b, 1'b0};
        for (int n = 0; n < 11; n++) begin
            @(posedge sysclk);
            rx_line <= frame[n];
            repeat (baud_div - 1) @(posedge sysclk);
        end
    endtask

    task automatic build_program();
        int k;
        int target;
        for (int a = 0; a < prog_len - 4; a++) begin
            k = $urandom_range(5, 0);
            target = $urandom_range(prog_len - 4, a + 1);
            case (k)
                0: prog_words[a] = {op_nop, 12'h000};
                1: prog_words[a] = {op_ldi, 4'h0, 8'($urandom)};
                2: prog_words[a] = {op_rd, 9'h000, 3'($urandom_range(7, 0))};
                3: prog_words[a] = {op_wr, 9'h000, 3'($urandom_range(7, 0))};
                4: prog_words[a] = {op_add, 9'h000, 3'($urandom_range(7, 0))};
                default: prog_words[a] = {op_jmp, 6'h00, 6'(target)};
            endcase
        end
        // forward jumps cannot pass the tail so it always runs
        prog_words[prog_len-4] = {op_wr, 9'h000, 3'd7};
        prog_words[prog_len-3] = {op_add, 9'h000, 3'd7};
        prog_words[prog_len-2] = {op_wr, 9'h000, 3'($urandom_range(6, 0))};
        prog_words[prog_len-1] = {op_hlt, 12'h000};
        for (int a = 0; a < prog_len; a++) begin
            chk.prog[a] = prog_words[a];
        end
    endtask

    task automatic run_program(input logic stall);
        int cycles;
        int stretch;
        for (int i = 0; i < top_reg; i++) begin
            chk.start_regs[i] = r[i];
        end
        chk.predict();
        // target leaves reset inside a stall stretch
        if (stall) begin
            @(posedge sysclk);
            mcu_wait <= 1'b1;
        end
        send_byte(cmd_run);
        cycles = 0;
        stretch = 0;
        do begin
            @(posedge sysclk);
            if (stall) begin
                if (stretch == 0) begin
                    stretch = $urandom_range(6, 1);
                    mcu_wait <= !mcu_wait;
                end else begin
                    stretch--;
                end
            end
            @(negedge sysclk);
            cycles++;
        end while (chk.pending() != 0 && cycles < run_limit);
        @(posedge sysclk);
        mcu_wait <= 1'b0;
        if (cycles >= run_limit) begin
            chk.note_failure("program run did not give all predicted strobes");
        end
        // halted target must stay quiet
        repeat (40) @(posedge sysclk);
        send_byte(cmd_halt);
        repeat (20) @(posedge sysclk);
    endtask

    task automatic check_peek();
        int base;
        int cycles;
        @(negedge sysclk);
        base = chk.replies;
        send_byte(cmd_peek);
        cycles = 0;
        do begin
            @(negedge sysclk);
            cycles++;
        end while (chk.replies == base && cycles < 3 * frame_cycles);
        if (chk.replies == base) begin
            chk.note_failure("no peek reply came back");
        end
    endtask

    task automatic check_avwr();
        logic [word_w-1:0] addr;
        logic [word_w-1:0] data;
        int                base;
        int                cycles;
        addr = 16'($urandom);
        data = 16'($urandom);
        chk.expect_av(addr, data);
        @(negedge sysclk);
        base = chk.av_done;
        send_byte(cmd_avwr);
        send_byte(addr[15:8]);
        send_byte(addr[7:0]);
        send_byte(data[15:8]);
        send_byte(data[7:0]);
        cycles = 0;
        do begin
            @(negedge sysclk);
            cycles++;
        end while (chk.av_done == base && cycles < 400);
        if (chk.av_done == base) begin
            chk.note_failure("Avalon write never completed");
        end
        repeat (20) @(posedge sysclk);
    endtask

    initial begin : watchdog
        #(watchdog_ns);
        $display("Error: watchdog expired before the test sequence finished");
        chk.report();
        $display("Checks failed");
        $finish;
    end

    initial begin
        void'($urandom(95));
        arst_n = 1'b0;
        mcu_wait = 1'b0;
        rx_line = 1'b1;
        build_program();
        repeat (3) @(posedge sysclk);
        arst_n <= 1'b1;
        repeat (4) @(posedge sysclk);
        for (int a = 0; a < prog_len; a++) begin
            send_byte(cmd_load);
            send_byte(8'(a));
            send_byte(prog_words[a][15:8]);
            send_byte(prog_words[a][7:0]);
        end
        run_program(1'b0);
        // restart from address 0 with stalls
        run_program(1'b1);
        check_peek();
        repeat (3) check_avwr();
        if (chk.pending() != 0) begin
            chk.note_failure("predicted strobes were left over");
        end
        chk.report();
        if (chk.total_errors() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: project.f
source/synapse_pkg.sv
source/synapse316.sv
source/async_serial.sv
source/visor.sv
source/supervised_synapse316.sv
verification/synapse_checker.sv
verification/tb_supervised_synapse316.sv

// File: run.sh
#!/bin/sh
# build and run the testbench, the log decides pass or fail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f \
    --top-module tb_supervised_synapse316 \
    -Mdir obj_dir -o tb_sim > sim.log 2>&1 \
    && ./obj_dir/tb_sim >> sim.log 2>&1

grep -q "All checks passed" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed, see sim.log"; exit 1; }
